/* src/rhythm_pkg.sv */
`default_nettype none

package rhythm_pkg;

    // Low seven bits one-hot C..B, bit 7 octave up, bit 8 octave down
    typedef logic [8:0]  note_t;

    // Bit 0 any octave shift, bits 7..1 keys C..B
    typedef logic [7:0]  led_t;

    // Eight ASCII characters, leftmost in the top byte
    typedef logic [63:0] seg_text_t;

    typedef logic [13:0] score_t;
    typedef logic [15:0] note_index_t;
    typedef logic [7:0]  id_t;

    // Top bit 0 for a note word, 1 for the final score word
    typedef logic [15:0] rec_word_t;

    typedef logic [1:0]  cfg_addr_t;

    localparam cfg_addr_t CFG_MODE   = 2'd0;
    localparam cfg_addr_t CFG_LENGTH = 2'd1;
    localparam cfg_addr_t CFG_USER   = 2'd2;
    localparam cfg_addr_t CFG_CHART  = 2'd3;

    typedef enum logic [2:0] {
        COUNT_3,
        COUNT_2,
        COUNT_1,
        COUNT_0,
        PLAYING
    } count_state_t;

endpackage

`default_nettype wire

/* src/play_config.sv */
`timescale 1ns/1ns
`default_nettype none

module play_config (
    input  wire logic                  prog_clk,
    input  wire logic                  rst,
    input  wire logic                  cfg_we,
    input  wire rhythm_pkg::cfg_addr_t cfg_addr,
    input  wire logic [15:0]           cfg_wdata,
    output logic [15:0]                cfg_rdata,
    output logic                       auto_play,
    output rhythm_pkg::note_index_t    chart_length,
    output rhythm_pkg::id_t            user_id,
    output rhythm_pkg::id_t            chart_id
);
    import rhythm_pkg::*;

    // Host writes land on the next edge
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            auto_play    <= 1'b0;
            chart_length <= '0;
            user_id      <= '0;
            chart_id     <= '0;
        end else if (cfg_we) begin
            case (cfg_addr)
                CFG_MODE:   auto_play    <= cfg_wdata[0];
                CFG_LENGTH: chart_length <= cfg_wdata;
                CFG_USER:   user_id      <= cfg_wdata[7:0];
                CFG_CHART:  chart_id     <= cfg_wdata[7:0];
                default:    ;
            endcase
        end
    end

    // IDs only come back to the host here
    always_comb begin
        case (cfg_addr)
            CFG_MODE:   cfg_rdata = {15'd0, auto_play};
            CFG_LENGTH: cfg_rdata = chart_length;
            CFG_USER:   cfg_rdata = {8'd0, user_id};
            CFG_CHART:  cfg_rdata = {8'd0, chart_id};
            default:    cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/countdown_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module countdown_timer #(
    parameter int BEAT_TICKS = 8
) (
    input  wire logic  prog_clk,
    input  wire logic  rst,
    output logic [1:0] count_digit,
    output logic       playing
);
    import rhythm_pkg::*;

    localparam int TICK_W = (BEAT_TICKS > 1) ? $clog2(BEAT_TICKS) : 1;

    count_state_t      state;
    logic [TICK_W-1:0] tick;
    logic              beat_done;

    assign beat_done = (tick == TICK_W'(BEAT_TICKS - 1));

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state <= COUNT_3;
            tick  <= '0;
        end else if (state != PLAYING) begin
            if (beat_done) begin
                tick <= '0;
                case (state)
                    COUNT_3: state <= COUNT_2;
                    COUNT_2: state <= COUNT_1;
                    COUNT_1: state <= COUNT_0;
                    default: state <= PLAYING;
                endcase
            end else begin
                tick <= tick + 1'b1;
            end
        end
    end

    // Digit shown during the count, zero once play runs
    always_comb begin
        case (state)
            COUNT_3: count_digit = 2'd3;
            COUNT_2: count_digit = 2'd2;
            COUNT_1: count_digit = 2'd1;
            default: count_digit = 2'd0;
        endcase
    end

    assign playing = (state == PLAYING);

endmodule

`default_nettype wire

/* src/note_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module note_sequencer #(
    parameter int NOTE_DIV = 12
) (
    input  wire logic                    prog_clk,
    input  wire logic                    rst,
    input  wire logic                    playing,
    input  wire logic                    auto_play,
    input  wire rhythm_pkg::note_index_t chart_length,
    input  wire rhythm_pkg::note_t       keys,
    input  wire logic                    exit_key,
    input  wire rhythm_pkg::note_t       chart_note,
    output rhythm_pkg::note_index_t      chart_addr,
    output rhythm_pkg::note_t            target_note,
    output logic                         active,
    output logic                         finished,
    output logic                         exited,
    output logic                         note_step,
    output rhythm_pkg::note_t            played_note
);
    import rhythm_pkg::*;

    localparam int DIV_W = (NOTE_DIV > 1) ? $clog2(NOTE_DIV) : 1;

    note_index_t      note_index;
    logic [DIV_W-1:0] div_cnt;
    logic             step;
    logic             finished_q;
    logic             exit_allowed;

    // Done once the index reaches the length, which covers a zero length
    assign finished = playing && (finished_q || (note_index >= chart_length));
    assign active   = playing && !finished && !exited;
    assign step     = active && (div_cnt == DIV_W'(NOTE_DIV - 1));

    // Auto play keeps the player in for the first notes
    assign exit_allowed = !auto_play || (note_index > note_index_t'(5));

    assign chart_addr  = note_index;
    assign target_note = chart_note;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            note_index <= '0;
            div_cnt    <= '0;
            finished_q <= 1'b0;
            exited     <= 1'b0;
            note_step  <= 1'b0;
        end else begin
            note_step <= step;
            if (finished)
                finished_q <= 1'b1;
            if (active && exit_key && exit_allowed)
                exited <= 1'b1;
            if (active)
                div_cnt <= step ? '0 : div_cnt + 1'b1;
            if (step)
                note_index <= note_index + 1'b1;
        end
    end

    // Valid on the cycle that note_step pulses
    always_ff @(posedge prog_clk) begin
        if (step)
            played_note <= auto_play ? target_note : keys;
    end

endmodule

`default_nettype wire

/* src/score_judge.sv */
`timescale 1ns/1ns
`default_nettype none

module score_judge #(
    parameter int SCAN_DIV = 4
) (
    input  wire logic              prog_clk,
    input  wire logic              rst,
    input  wire logic              active,
    input  wire logic              auto_play,
    input  wire rhythm_pkg::note_t keys,
    input  wire rhythm_pkg::note_t target_note,
    output rhythm_pkg::score_t     score
);
    import rhythm_pkg::*;

    localparam int SCAN_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [SCAN_W-1:0] scan_cnt;
    logic              scan;
    note_t             key_hist_1;
    note_t             key_hist_2;
    logic [3:0]        points;
    logic [14:0]       score_sum;

    // Counter only runs in play, so scans stay in phase with note steps
    assign scan = active && (scan_cnt == SCAN_W'(SCAN_DIV - 1));

    // Closest match in time wins
    always_comb begin
        if (auto_play)
            points = 4'd4;
        else if (target_note == keys)
            points = 4'd5;
        else if (target_note == key_hist_1)
            points = 4'd3;
        else if (target_note == key_hist_2)
            points = 4'd1;
        else
            points = 4'd0;
    end

    assign score_sum = {1'b0, score} + {11'd0, points};

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            scan_cnt   <= '0;
            key_hist_1 <= '0;
            key_hist_2 <= '0;
            score      <= '0;
        end else begin
            if (active)
                scan_cnt <= scan ? '0 : scan_cnt + 1'b1;
            if (scan) begin
                // Saturate at the top of the range
                score <= score_sum[14] ? '1 : score_sum[13:0];
                if (!auto_play) begin
                    key_hist_1 <= keys;
                    key_hist_2 <= key_hist_1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/note_indicator.sv */
`timescale 1ns/1ns
`default_nettype none

module note_indicator (
    input  wire logic              prog_clk,
    input  wire logic              rst,
    input  wire logic              active,
    input  wire rhythm_pkg::note_t target_note,
    output rhythm_pkg::led_t       led,
    output rhythm_pkg::seg_text_t  seg_text
);
    import rhythm_pkg::*;

    localparam logic [55:0] LETTERS = "cdefgab";
    localparam seg_text_t   BLANK   = "        ";

    logic       note_valid;
    logic [2:0] key_pos;
    logic [7:0] letter_char;
    logic [7:0] octave_char;
    logic [7:0] digit_char;

    // Position of the single set key bit
    function automatic logic [2:0] find_key(input note_t n);
        logic [2:0] pos;
        pos = 3'd0;
        for (int i = 0; i < 7; i++) begin
            if (n[i])
                pos = 3'(i);
        end
        return pos;
    endfunction

    // A rest or a chord decodes as invalid too
    assign note_valid = $onehot(target_note[6:0]) && !(&target_note[8:7]);
    assign key_pos    = find_key(target_note);

    assign letter_char = LETTERS[8 * (6 - key_pos) +: 8];
    assign digit_char  = 8'("1") + 8'(key_pos);
    assign octave_char = target_note[7] ? "u" : (target_note[8] ? "d" : " ");

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            led      <= '0;
            seg_text <= BLANK;
        end else if (active) begin
            if (note_valid) begin
                led[0] <= |target_note[8:7];
                // C lights the top LED
                for (int i = 0; i < 7; i++)
                    led[7 - i] <= target_note[i];
                seg_text <= {letter_char, " ", octave_char, " ", digit_char, "   "};
            end else begin
                led      <= '0;
                seg_text <= BLANK;
            end
        end
    end

endmodule

`default_nettype wire

/* src/record_writer.sv */
`timescale 1ns/1ns
`default_nettype none

module record_writer #(
    parameter int REC_CREDITS = 4,
    parameter int REC_DEPTH   = 4
) (
    input  wire logic               prog_clk,
    input  wire logic               rst,
    input  wire logic               note_step,
    input  wire rhythm_pkg::note_t  played_note,
    input  wire logic               finished,
    input  wire rhythm_pkg::score_t score,
    input  wire logic               rec_credit,
    output logic                    rec_valid,
    output rhythm_pkg::rec_word_t   rec_word,
    output logic                    rec_overflow
);
    import rhythm_pkg::*;

    localparam int PTR_W = (REC_DEPTH > 1) ? $clog2(REC_DEPTH) : 1;
    localparam int CNT_W = $clog2(REC_DEPTH + 1);
    localparam int CRD_W = $clog2(REC_CREDITS + 1);

    rec_word_t        fifo_mem [REC_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic [CRD_W-1:0] credits;
    logic             finished_q;
    logic             score_push;
    logic             push;
    logic             push_ok;
    logic             send;
    rec_word_t        push_word;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(REC_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push      = note_step || score_push;
    assign push_word = score_push ? {2'b10, score} : {7'd0, played_note};
    assign push_ok   = push && (fill != CNT_W'(REC_DEPTH));

    // One word per cycle while a credit is held
    assign send = (fill != '0) && (credits != '0);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fill         <= '0;
            credits      <= CRD_W'(REC_CREDITS);
            finished_q   <= 1'b0;
            score_push   <= 1'b0;
            rec_valid    <= 1'b0;
            rec_overflow <= 1'b0;
        end else begin
            finished_q <= finished;
            score_push <= finished && !finished_q;
            rec_valid  <= send;
            if (push_ok)
                wr_ptr <= ptr_next(wr_ptr);
            if (send)
                rd_ptr <= ptr_next(rd_ptr);
            fill <= fill + CNT_W'(push_ok) - CNT_W'(send);
            if (send && !rec_credit)
                credits <= credits - 1'b1;
            else if (!send && rec_credit && (credits != CRD_W'(REC_CREDITS)))
                credits <= credits + 1'b1;
            if (push && !push_ok)
                rec_overflow <= 1'b1;
        end
    end

    always_ff @(posedge prog_clk) begin
        if (push_ok)
            fifo_mem[wr_ptr] <= push_word;
        if (send)
            rec_word <= fifo_mem[rd_ptr];
    end

endmodule

`default_nettype wire

/* src/play_top.sv */
`timescale 1ns/1ns
`default_nettype none

module play_top #(
    parameter int NOTE_DIV    = 12,
    parameter int SCAN_DIV    = 4,
    parameter int BEAT_TICKS  = 8,
    parameter int REC_CREDITS = 4,
    parameter int REC_DEPTH   = 4
) (
    input  wire logic                  prog_clk,
    input  wire logic                  rst,
    input  wire logic                  cfg_we,
    input  wire rhythm_pkg::cfg_addr_t cfg_addr,
    input  wire logic [15:0]           cfg_wdata,
    input  wire rhythm_pkg::note_t     keys,
    input  wire logic                  exit_key,
    input  wire rhythm_pkg::note_t     chart_note,
    input  wire logic                  rec_credit,
    output logic [15:0]                cfg_rdata,
    output rhythm_pkg::note_index_t    chart_addr,
    output logic [1:0]                 count_digit,
    output logic                       playing,
    output logic                       finished,
    output logic                       exited,
    output rhythm_pkg::score_t         score,
    output rhythm_pkg::led_t           led,
    output rhythm_pkg::seg_text_t      seg_text,
    output logic                       rec_valid,
    output rhythm_pkg::rec_word_t      rec_word,
    output logic                       rec_overflow
);
    import rhythm_pkg::*;

    logic        auto_play;
    note_index_t chart_length;
    note_t       target_note;
    note_t       played_note;
    logic        active;
    logic        note_step;

    // IDs stay inside the register block for host read-back
    play_config config_i (
        .prog_clk(prog_clk), .rst(rst),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .cfg_rdata(cfg_rdata), .auto_play(auto_play), .chart_length(chart_length),
        .user_id(), .chart_id()
    );

    countdown_timer #(.BEAT_TICKS(BEAT_TICKS)) countdown_i (
        .prog_clk(prog_clk), .rst(rst),
        .count_digit(count_digit), .playing(playing)
    );

    // Active comes from here and gates the judge and the display
    note_sequencer #(.NOTE_DIV(NOTE_DIV)) sequencer_i (
        .prog_clk(prog_clk), .rst(rst),
        .playing(playing), .auto_play(auto_play), .chart_length(chart_length),
        .keys(keys), .exit_key(exit_key), .chart_note(chart_note),
        .chart_addr(chart_addr), .target_note(target_note), .active(active),
        .finished(finished), .exited(exited),
        .note_step(note_step), .played_note(played_note)
    );

    score_judge #(.SCAN_DIV(SCAN_DIV)) judge_i (
        .prog_clk(prog_clk), .rst(rst),
        .active(active), .auto_play(auto_play),
        .keys(keys), .target_note(target_note),
        .score(score)
    );

    note_indicator indicator_i (
        .prog_clk(prog_clk), .rst(rst),
        .active(active), .target_note(target_note),
        .led(led), .seg_text(seg_text)
    );

    record_writer #(.REC_CREDITS(REC_CREDITS), .REC_DEPTH(REC_DEPTH)) writer_i (
        .prog_clk(prog_clk), .rst(rst),
        .note_step(note_step), .played_note(played_note),
        .finished(finished), .score(score), .rec_credit(rec_credit),
        .rec_valid(rec_valid), .rec_word(rec_word), .rec_overflow(rec_overflow)
    );

endmodule

`default_nettype wire

/* test/tb_play_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_play_top;
    import rhythm_pkg::*;

    logic prog_clk = 1'b0;
    logic rst = 1'b1;
    logic cfg_we = 1'b0;
    logic exit_key = 1'b0;
    logic rec_credit = 1'b0;
    cfg_addr_t cfg_addr = '0;
    logic [15:0] cfg_wdata = '0;
    note_t keys = '0;
    note_t chart_note;
    logic [15:0] cfg_rdata;
    note_index_t chart_addr;
    logic [1:0] count_digit;
    logic playing, finished, exited, rec_valid, rec_overflow;
    score_t score;
    led_t led;
    seg_text_t seg_text;
    rec_word_t rec_word;

    note_t chart [16];
    rec_word_t exp_words [16];
    integer seed = 36;
    int errors = 0;
    int timeouts = 0;
    int cyc, rx_idx, last_idx, held_sent, owed, exp_len, bp_len;
    logic [15:0] rd_exp;
    score_t exp_score;
    logic rd_check = 0;
    logic sc_check = 0;
    logic fin_check = 0;
    logic bp_mode = 0;
    logic hold_credits = 0;
    logic ovf_check = 0;
    logic hold_check = 0;
    logic auto_exit_chk = 0;
    logic rand_keys = 0;
    logic prev_active, prev_exited;
    note_t prev_note;
    note_index_t prev_addr;

    play_top #(
        .NOTE_DIV(12), .SCAN_DIV(4), .BEAT_TICKS(8), .REC_CREDITS(4), .REC_DEPTH(4)
    ) dut_i (
        .prog_clk(prog_clk), .rst(rst), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .keys(keys), .exit_key(exit_key), .chart_note(chart_note),
        .rec_credit(rec_credit), .cfg_rdata(cfg_rdata), .chart_addr(chart_addr),
        .count_digit(count_digit), .playing(playing), .finished(finished), .exited(exited),
        .score(score), .led(led), .seg_text(seg_text), .rec_valid(rec_valid),
        .rec_word(rec_word), .rec_overflow(rec_overflow)
    );

    always #10 prog_clk = ~prog_clk;

    // Combinational chart memory
    assign chart_note = (chart_addr < 16) ? chart[chart_addr[3:0]] : '0;

    function automatic logic note_ok(input note_t n);
        int ones;
        ones = 0;
        for (int i = 0; i < 7; i++)
            ones += n[i];
        return (ones == 1) && !(n[7] && n[8]);
    endfunction

    function automatic led_t led_of(input note_t n);
        led_t l;
        l = '0;
        if (note_ok(n)) begin
            l[0] = (n[8:7] != 2'b00);
            // C on the top LED down to B on bit 1
            l[7:1] = {n[0], n[1], n[2], n[3], n[4], n[5], n[6]};
        end
        return l;
    endfunction

    function automatic seg_text_t text_of(input note_t n);
        int k;
        logic [7:0] letter, oct;
        k = 0;
        if (!note_ok(n))
            return "        ";
        for (int i = 0; i < 7; i++)
            if (n[i]) k = i;
        letter = (k < 5) ? 8'("c") + 8'(k) : 8'("a") + 8'(k - 5);
        oct = n[7] ? "u" : (n[8] ? "d" : " ");
        return {letter, " ", oct, " ", 8'("1") + 8'(k), "   "};
    endfunction

    // Chart position of a record word
    // Score words sort after every note
    function automatic int idx_of(input rec_word_t w);
        if (w[15])
            return 100;
        for (int i = 0; i < bp_len; i++)
            if (w == {7'd0, chart[i]}) return i;
        return -2;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        errors++;
        $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
    endtask

    always @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            cyc <= 0;
            rx_idx <= 0;
            last_idx <= -1;
            held_sent <= 0;
            prev_active <= 1'b0;
            prev_exited <= 1'b0;
            prev_note <= '0;
            prev_addr <= '0;
        end else begin
            cyc <= cyc + 1;
            prev_active <= playing && !finished && !exited;
            prev_note   <= chart_note;
            prev_exited <= exited;
            prev_addr   <= chart_addr;
            if (rec_valid) begin
                rx_idx   <= rx_idx + 1;
                last_idx <= idx_of(rec_word);
                if (hold_credits)
                    held_sent <= held_sent + 1;
            end
        end
    end

    // Store frees each word one cycle later unless credits are held back
    always @(posedge prog_clk) begin
        #2;
        if (rst) begin
            owed = 0;
            rec_credit = 1'b0;
        end else begin
            if (rec_valid)
                owed = owed + 1;
            rec_credit = !hold_credits && (owed > 0);
            if (rec_credit)
                owed = owed - 1;
        end
        if (rand_keys)
            keys = note_t'($random(seed));
    end

    a_reset_state: assert property (@(posedge prog_clk) disable iff (rst)
        (cyc == 0) |-> {rec_valid, playing, finished, exited, rec_overflow} == '0)
        else report_mismatch("reset_state", 0,
                             {rec_valid, playing, finished, exited, rec_overflow});
    a_count: assert property (@(posedge prog_clk) disable iff (rst)
        (cyc < 32) |-> count_digit == 2'(3 - cyc / 8))
        else report_mismatch("count_digit", 2'(3 - cyc / 8), count_digit);
    a_playing: assert property (@(posedge prog_clk) disable iff (rst)
        playing == (cyc >= 32)) else report_mismatch("playing", cyc >= 32, playing);
    a_finish: assert property (@(posedge prog_clk) disable iff (rst)
        fin_check |-> finished == (cyc >= 32 + exp_len * 12))
        else report_mismatch("finished", cyc >= 32 + exp_len * 12, finished);
    a_led: assert property (@(posedge prog_clk) disable iff (rst)
        prev_active |-> led == led_of(prev_note))
        else report_mismatch("led", led_of(prev_note), led);
    a_seg: assert property (@(posedge prog_clk) disable iff (rst)
        prev_active |-> seg_text == text_of(prev_note))
        else report_mismatch("seg_text", text_of(prev_note), seg_text);
    a_record: assert property (@(posedge prog_clk) disable iff (rst)
        (rec_valid && !bp_mode) |-> rec_word == exp_words[rx_idx[3:0]])
        else report_mismatch("record", exp_words[rx_idx[3:0]], rec_word);
    a_order: assert property (@(posedge prog_clk) disable iff (rst)
        (rec_valid && bp_mode) |-> idx_of(rec_word) > last_idx)
        else report_mismatch("record_order", last_idx + 1, idx_of(rec_word));
    a_credit_limit: assert property (@(posedge prog_clk) disable iff (rst)
        held_sent <= 4) else report_mismatch("credit_limit", 4, held_sent);
    a_overflow: assert property (@(posedge prog_clk) disable iff (rst)
        ovf_check |-> rec_overflow) else report_mismatch("overflow", 1, rec_overflow);
    a_score: assert property (@(posedge prog_clk) disable iff (rst)
        sc_check |-> score == exp_score) else report_mismatch("score", exp_score, score);
    a_cfg: assert property (@(posedge prog_clk) disable iff (rst)
        rd_check |-> cfg_rdata == rd_exp) else report_mismatch("cfg_read", rd_exp, cfg_rdata);
    a_exit_hold: assert property (@(posedge prog_clk) disable iff (rst)
        (hold_check && prev_exited) |-> (chart_addr == prev_addr) && !finished)
        else report_mismatch("exit_hold", {prev_addr, 1'b0}, {chart_addr, finished});
    a_auto_exit: assert property (@(posedge prog_clk) disable iff (rst)
        auto_exit_chk |-> !exited) else report_mismatch("auto_exit", 0, exited);

    task automatic write_cfg(input cfg_addr_t addr, input logic [15:0] data);
        cfg_we = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        @(posedge prog_clk) #2;
        cfg_we = 1'b0;
    endtask

    task automatic read_cfg(input cfg_addr_t addr, input logic [15:0] exp);
        cfg_addr = addr;
        rd_exp = exp;
        rd_check = 1'b1;
        @(posedge prog_clk) #2;
        rd_check = 1'b0;
    endtask

    task automatic start_run(input logic auto, input int len);
        rst = 1'b1;
        keys = '0;
        exit_key = 1'b0;
        exp_len = len;
        for (int i = 0; i < 16; i++)
            exp_words[i] = '0;
        repeat (3) @(posedge prog_clk);
        #2 rst = 1'b0;
        write_cfg(CFG_MODE, {15'd0, auto});
        write_cfg(CFG_LENGTH, 16'(len));
    endtask

    task automatic check_score(input score_t v);
        exp_score = v;
        sc_check = 1'b1;
        @(posedge prog_clk) #2;
        sc_check = 1'b0;
    endtask

    task automatic wait_finished(input int limit);
        int n;
        n = 0;
        do begin
            @(posedge prog_clk) #2;
            n++;
        end while (!finished && n < limit);
        if (!finished) begin
            timeouts++;
            $display("Timeout: finished never rose");
        end
    endtask

    task automatic wait_exited(input int limit);
        int n;
        n = 0;
        do begin
            @(posedge prog_clk) #2;
            n++;
        end while (!exited && n < limit);
        if (!exited) begin
            timeouts++;
            $display("Timeout: exit key did not stop play");
        end
    endtask

    task automatic wait_addr(input int a, input int limit);
        int n;
        n = 0;
        do begin
            @(posedge prog_clk) #2;
            n++;
        end while (chart_addr != a && n < limit);
        if (chart_addr != a) begin
            timeouts++;
            $display("Timeout: chart address stuck");
        end
    endtask

    task automatic wait_rx(input int cnt, input int limit);
        int n;
        n = 0;
        do begin
            @(posedge prog_clk) #2;
            n++;
        end while (rx_idx < cnt && n < limit);
        if (rx_idx < cnt) begin
            timeouts++;
            $display("Timeout: record words missing");
        end
    endtask

    initial begin
        for (int i = 0; i < 16; i++)
            chart[i] = note_t'(1 << (i % 7)) | ((i >= 7) ? 9'h080 : 9'h000);
        // Auto play with random keys and config read-back
        chart[1] = 9'h082;
        chart[2] = 9'h104;
        start_run(1'b1, 6);
        write_cfg(CFG_USER, 16'h005a);
        write_cfg(CFG_CHART, 16'h00c3);
        read_cfg(CFG_MODE, 16'h0001);
        read_cfg(CFG_LENGTH, 16'd6);
        read_cfg(CFG_USER, 16'h005a);
        read_cfg(CFG_CHART, 16'h00c3);
        for (int i = 0; i < 6; i++)
            exp_words[i] = {7'd0, chart[i]};
        exp_words[6] = {2'b10, 14'd72};
        rand_keys = 1'b1;
        fin_check = 1'b1;
        wait_finished(200);
        wait_rx(7, 100);
        check_score(14'd72);
        rand_keys = 1'b0;
        // Manual scoring with keys on the note and then on a rest
        for (int run = 0; run < 2; run++) begin
            for (int i = 0; i < 4; i++)
                chart[i] = 9'h010;
            start_run(1'b0, 4);
            keys = (run == 0) ? 9'h010 : 9'h000;
            for (int i = 0; i < 4; i++)
                exp_words[i] = {7'd0, keys};
            exp_words[4] = {2'b10, (run == 0) ? 14'd60 : 14'd0};
            wait_finished(200);
            wait_rx(5, 100);
            check_score((run == 0) ? 14'd60 : 14'd0);
        end
        // Back-pressure with distinct notes
        for (int i = 0; i < 16; i++)
            chart[i] = note_t'(1 << (i % 7)) | ((i >= 7) ? 9'h080 : 9'h000);
        bp_len = 10;
        bp_mode = 1'b1;
        hold_credits = 1'b1;
        start_run(1'b1, 10);
        wait_finished(300);
        repeat (3) @(posedge prog_clk);
        #2 ovf_check = 1'b1;
        hold_credits = 1'b0;
        wait_rx(8, 100);
        ovf_check = 1'b0;
        bp_mode = 1'b0;
        // Manual exit with an invalid note in the chart
        chart[1] = 9'h181;
        fin_check = 1'b0;
        start_run(1'b0, 8);
        wait_addr(3, 200);
        exit_key = 1'b1;
        wait_exited(10);
        exit_key = 1'b0;
        hold_check = 1'b1;
        repeat (60) @(posedge prog_clk);
        #2 hold_check = 1'b0;
        // Auto mode ignores exit up to and including position 5
        chart[1] = 9'h002;
        start_run(1'b1, 8);
        for (int i = 0; i < 8; i++)
            exp_words[i] = {7'd0, chart[i]};
        exp_words[8] = {2'b10, 14'd96};
        fin_check = 1'b1;
        auto_exit_chk = 1'b1;
        wait_addr(1, 200);
        exit_key = 1'b1;
        wait_addr(6, 100);
        exit_key = 1'b0;
        wait_finished(200);
        wait_rx(9, 100);
        auto_exit_chk = 1'b0;
        fin_check = 1'b0;
        $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
src/rhythm_pkg.sv
src/play_config.sv
src/countdown_timer.sv
src/note_sequencer.sv
src/score_judge.sv
src/note_indicator.sv
src/record_writer.sv
src/play_top.sv
test/tb_play_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_play_top
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
